// File: source/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int WORD_SIZE = 32;
    localparam int ADDR_SIZE = 32;
    localparam int REG_SIZE  = 5;

    // Distance to the next sequential instruction
    localparam int PC_INCR   = 4;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        // Conditional branches
        ALU_BEQ  = 5'd10,
        ALU_BNE  = 5'd11,
        ALU_BLT  = 5'd12,
        ALU_BGE  = 5'd13,
        ALU_BLTU = 5'd14,
        ALU_BGEU = 5'd15,
        // Unconditional jumps
        ALU_JAL  = 5'd16,
        ALU_JALR = 5'd17
    } alu_opcode_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } memop_type_e;

    typedef struct packed {
        logic                 valid;
        alu_opcode_e          alu_opcode;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        memop_type_e          memop_type;
        logic                 memop_rd;
        logic                 memop_wr;
        logic                 memop_sign_ext;
        logic                 finish_test;
        logic [WORD_SIZE-1:0] alu_src_a;
        logic [WORD_SIZE-1:0] alu_src_b;
        logic [WORD_SIZE-1:0] br_src_a;
        logic [WORD_SIZE-1:0] br_src_b;
        logic [WORD_SIZE-1:0] rf_st_data;
        logic [ADDR_SIZE-1:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        memop_type_e          memop_type;
        logic                 memop_rd;
        logic                 memop_wr;
        logic                 memop_sign_ext;
        logic                 is_jump;
        logic                 finish_test;
        logic [WORD_SIZE-1:0] alu_res;
        logic [WORD_SIZE-1:0] rf_st_data;
        logic [ADDR_SIZE-1:0] seq_pc;
    } ex_mem_t;

endpackage : ex_pkg

`default_nettype wire

// File: source/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  alu_opcode_e          alu_opcode_i,
    input  logic [WORD_SIZE-1:0] src_a_i,
    input  logic [WORD_SIZE-1:0] src_b_i,
    output logic [WORD_SIZE-1:0] alu_res_o
);

    logic [WORD_SIZE-1:0] sum;
    logic [WORD_SIZE-1:0] diff;
    logic [4:0]           shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;

    // Shared adder, also forms branch and jump targets
    assign sum   = src_a_i + src_b_i;
    assign diff  = src_a_i - src_b_i;
    assign shamt = src_b_i[4:0];

    assign lt_signed   = $signed(src_a_i) < $signed(src_b_i);
    assign lt_unsigned = src_a_i < src_b_i;

    always_comb begin
        case (alu_opcode_i)
            ALU_ADD: begin
                alu_res_o = sum;
            end
            ALU_SUB: begin
                alu_res_o = diff;
            end
            ALU_AND: begin
                alu_res_o = src_a_i & src_b_i;
            end
            ALU_OR: begin
                alu_res_o = src_a_i | src_b_i;
            end
            ALU_XOR: begin
                alu_res_o = src_a_i ^ src_b_i;
            end
            ALU_SLL: begin
                alu_res_o = src_a_i << shamt;
            end
            ALU_SRL: begin
                alu_res_o = src_a_i >> shamt;
            end
            ALU_SRA: begin
                alu_res_o = WORD_SIZE'($signed(src_a_i) >>> shamt);
            end
            ALU_SLT: begin
                alu_res_o = {{(WORD_SIZE-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                alu_res_o = {{(WORD_SIZE-1){1'b0}}, lt_unsigned};
            end
            // Operands here are pc or rs1 plus the immediate
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
            ALU_JAL, ALU_JALR: begin
                alu_res_o = sum;
            end
            default: begin
                alu_res_o = sum;
            end
        endcase
    end

endmodule : ex_alu

`default_nettype wire

// File: source/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
    import ex_pkg::*;
(
    input  alu_opcode_e          alu_opcode_i,
    input  logic [WORD_SIZE-1:0] br_src_a_i,
    input  logic [WORD_SIZE-1:0] br_src_b_i,
    output logic                 taken_o,
    output logic                 is_jump_o
);

    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    assign equal       = br_src_a_i == br_src_b_i;
    assign lt_signed   = $signed(br_src_a_i) < $signed(br_src_b_i);
    assign lt_unsigned = br_src_a_i < br_src_b_i;

    assign is_jump_o = (alu_opcode_i == ALU_JAL) || (alu_opcode_i == ALU_JALR);

    always_comb begin
        case (alu_opcode_i)
            ALU_BEQ:  taken_o = equal;
            ALU_BNE:  taken_o = !equal;
            ALU_BLT:  taken_o = lt_signed;
            ALU_BGE:  taken_o = !lt_signed;
            ALU_BLTU: taken_o = lt_unsigned;
            ALU_BGEU: taken_o = !lt_unsigned;
            // Jumps always redirect
            ALU_JAL,
            ALU_JALR: taken_o = 1'b1;
            default:  taken_o = 1'b0;
        endcase
    end

endmodule : ex_branch_unit

`default_nettype wire

// File: source/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Pipeline control from the hazard logic
    input  logic                 stall_i,
    input  logic                 flush_i,

    // Decoded instruction from ID
    input  id_ex_t               id_ex_i,

    // Result toward MEM
    output ex_mem_t              ex_mem_o,

    // Redirect toward fetch
    output logic                 taken_o,
    output logic [ADDR_SIZE-1:0] target_o
);

    id_ex_t id_ex_d;
    id_ex_t id_ex_q;

    logic [WORD_SIZE-1:0] alu_res;
    logic                 br_taken;
    logic                 is_jump;
    logic [ADDR_SIZE-1:0] seq_pc;
    logic [ADDR_SIZE-1:0] jump_target;

    // Clears every control bit that could change architectural state
    function automatic id_ex_t make_bubble(input id_ex_t ins);
        id_ex_t bubble;
        bubble                = ins;
        bubble.valid          = 1'b0;
        bubble.rf_we          = 1'b0;
        bubble.memop_rd       = 1'b0;
        bubble.memop_wr       = 1'b0;
        bubble.finish_test    = 1'b0;
        bubble.alu_opcode     = ALU_ADD;
        return bubble;
    endfunction

    // ID/EX next state, stall has priority over flush
    always_comb begin
        if (stall_i) begin
            id_ex_d = id_ex_q;
        end else if (flush_i) begin
            id_ex_d = make_bubble(id_ex_i);
        end else begin
            id_ex_d = id_ex_i;
        end
    end

    // Payload keeps its value through reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_q <= make_bubble(id_ex_q);
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    ex_alu ex_alu_inst (
        .alu_opcode_i (id_ex_q.alu_opcode),
        .src_a_i      (id_ex_q.alu_src_a),
        .src_b_i      (id_ex_q.alu_src_b),
        .alu_res_o    (alu_res)
    );

    ex_branch_unit ex_branch_unit_inst (
        .alu_opcode_i (id_ex_q.alu_opcode),
        .br_src_a_i   (id_ex_q.br_src_a),
        .br_src_b_i   (id_ex_q.br_src_b),
        .taken_o      (br_taken),
        .is_jump_o    (is_jump)
    );

    assign seq_pc = id_ex_q.pc + ADDR_SIZE'(PC_INCR);

    // JALR target has its low bit forced to zero
    always_comb begin
        jump_target = alu_res[ADDR_SIZE-1:0];
        if (id_ex_q.alu_opcode == ALU_JALR) begin
            jump_target[0] = 1'b0;
        end
    end

    assign target_o = jump_target;

    // A bubble never redirects fetch
    assign taken_o = id_ex_q.valid & br_taken;

    always_comb begin
        ex_mem_o.valid          = id_ex_q.valid;
        ex_mem_o.rf_we          = id_ex_q.rf_we;
        ex_mem_o.rf_waddr       = id_ex_q.rf_waddr;
        ex_mem_o.memop_type     = id_ex_q.memop_type;
        ex_mem_o.memop_rd       = id_ex_q.memop_rd;
        ex_mem_o.memop_wr       = id_ex_q.memop_wr;
        ex_mem_o.memop_sign_ext = id_ex_q.memop_sign_ext;
        ex_mem_o.is_jump        = is_jump;
        ex_mem_o.finish_test    = id_ex_q.finish_test;
        ex_mem_o.rf_st_data     = id_ex_q.rf_st_data;
        ex_mem_o.seq_pc         = seq_pc;

        // Link value for jumps goes to rd
        if (is_jump) begin
            ex_mem_o.alu_res = WORD_SIZE'(seq_pc);
        end else begin
            ex_mem_o.alu_res = alu_res;
        end
    end

endmodule : ex_stage

`default_nettype wire

// File: test/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
    import ex_pkg::*;
;

    localparam int          NUM_TESTS      = 2000;
    localparam int          RESET_CYCLES   = 10;
    localparam int          IDLE_CYCLES    = 4;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS + RESET_CYCLES + IDLE_CYCLES + 100;
    localparam logic [31:0] LFSR_SEED      = 32'h6680_3e79;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 stall_i;
    logic                 flush_i;
    id_ex_t               id_ex_i;
    ex_mem_t              ex_mem_o;
    logic                 taken_o;
    logic [ADDR_SIZE-1:0] target_o;

    logic [31:0]          lfsr_state;
    int                   cycle_count;

    // Reference copy of the ID/EX register
    id_ex_t               model_q;
    logic                 model_known;

    // Outputs seen at the previous sample, for the stall check
    ex_mem_t              prev_ex_mem;
    logic                 prev_taken;
    logic [ADDR_SIZE-1:0] prev_target;

    ex_stage ex_stage_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .id_ex_i  (id_ex_i),
        .ex_mem_o (ex_mem_o),
        .taken_o  (taken_o),
        .target_o (target_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = {1'b0, s[31:1]};
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] ref_alu(input alu_opcode_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] res;
        case (op)
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            // ADD, branches and jumps all add
            default:  res = a + b;
        endcase
        return res;
    endfunction

    function automatic logic ref_taken(input alu_opcode_e op, input logic [31:0] a,
                                       input logic [31:0] b);
        logic t;
        case (op)
            ALU_BEQ:  t = (a == b);
            ALU_BNE:  t = (a != b);
            ALU_BLT:  t = ($signed(a) < $signed(b));
            ALU_BGE:  t = ($signed(a) >= $signed(b));
            ALU_BLTU: t = (a < b);
            ALU_BGEU: t = (a >= b);
            ALU_JAL:  t = 1'b1;
            ALU_JALR: t = 1'b1;
            default:  t = 1'b0;
        endcase
        return t;
    endfunction

    function automatic id_ex_t clear_control(input id_ex_t ins);
        id_ex_t b;
        b             = ins;
        b.valid       = 1'b0;
        b.rf_we       = 1'b0;
        b.memop_rd    = 1'b0;
        b.memop_wr    = 1'b0;
        b.finish_test = 1'b0;
        b.alu_opcode  = ALU_ADD;
        return b;
    endfunction

    // Inputs still hold the values seen at the last rising edge
    task automatic model_step();
        if (!rst_n_i) begin
            model_q = clear_control(model_q);
        end else if (stall_i) begin
            model_q = model_q;
        end else if (flush_i) begin
            model_q     = clear_control(id_ex_i);
            model_known = 1'b1;
        end else begin
            model_q     = id_ex_i;
            model_known = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
            $display("Some tests failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic check_cycle();
        logic [31:0] alu_val;
        logic [31:0] seq_pc;
        logic [31:0] exp_target;
        logic        jump;
        logic        exp_taken;
        model_step();
        alu_val    = ref_alu(model_q.alu_opcode, model_q.alu_src_a, model_q.alu_src_b);
        seq_pc     = model_q.pc + 32'd4;
        jump       = (model_q.alu_opcode == ALU_JAL) || (model_q.alu_opcode == ALU_JALR);
        exp_taken  = model_q.valid && ref_taken(model_q.alu_opcode, model_q.br_src_a,
                                                model_q.br_src_b);
        exp_target = alu_val;
        if (model_q.alu_opcode == ALU_JALR) begin
            exp_target[0] = 1'b0;
        end

        check_value("valid", 32'(ex_mem_o.valid), 32'(model_q.valid));
        check_value("rf_we", 32'(ex_mem_o.rf_we), 32'(model_q.rf_we));
        check_value("memop_rd", 32'(ex_mem_o.memop_rd), 32'(model_q.memop_rd));
        check_value("memop_wr", 32'(ex_mem_o.memop_wr), 32'(model_q.memop_wr));
        check_value("finish_test", 32'(ex_mem_o.finish_test), 32'(model_q.finish_test));
        check_value("is_jump", 32'(ex_mem_o.is_jump), 32'(jump));
        check_value("taken", 32'(taken_o), 32'(exp_taken));

        // Payload is undefined until the first load after power-up
        if (model_known) begin
            check_value("rf_waddr", 32'(ex_mem_o.rf_waddr), 32'(model_q.rf_waddr));
            check_value("memop_type", 32'(ex_mem_o.memop_type), 32'(model_q.memop_type));
            check_value("memop_sign_ext", 32'(ex_mem_o.memop_sign_ext),
                        32'(model_q.memop_sign_ext));
            check_value("rf_st_data", ex_mem_o.rf_st_data, model_q.rf_st_data);
            check_value("seq_pc", ex_mem_o.seq_pc, seq_pc);
            check_value("alu_res", ex_mem_o.alu_res, jump ? seq_pc : alu_val);
            check_value("target", target_o, exp_target);
        end

        if (rst_n_i && stall_i) begin
            assert (ex_mem_o === prev_ex_mem && taken_o === prev_taken &&
                    target_o === prev_target) else begin
                $display("[ERROR] %0t ns: outputs changed while stalled", $time);
                $display("Some tests failed");
                $fatal(1, "Stopping at first mismatch");
            end
        end

        prev_ex_mem = ex_mem_o;
        prev_taken  = taken_o;
        prev_target = target_o;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        id_ex_t      ins;
        ins = '0;
        // Stall and flush about one cycle in eight, valid three in four
        take_bits(3, r);
        stall_i = (r[2:0] == 3'd0);
        take_bits(3, r);
        flush_i = (r[2:0] == 3'd0);
        take_bits(2, r);
        ins.valid = (r[1:0] != 2'd0);
        take_bits(5, r);
        ins.alu_opcode = alu_opcode_e'(5'(r % 18));
        take_bits(1, r);
        ins.rf_we = r[0];
        take_bits(5, r);
        ins.rf_waddr = r[4:0];
        take_bits(2, r);
        ins.memop_type = memop_type_e'(2'(r % 3));
        take_bits(3, r);
        ins.memop_rd       = r[0];
        ins.memop_wr       = r[1];
        ins.memop_sign_ext = r[2];
        take_bits(4, r);
        ins.finish_test = (r[3:0] == 4'd0);
        take_bits(32, r);
        ins.alu_src_a = r;
        take_bits(32, r);
        ins.alu_src_b = r;
        take_bits(32, r);
        ins.br_src_a = r;
        // Equal branch operands often enough to hit BEQ and BGE edges
        take_bits(2, r);
        if (r[1:0] == 2'd0) begin
            ins.br_src_b = ins.br_src_a;
        end else begin
            take_bits(32, r);
            ins.br_src_b = r;
        end
        take_bits(32, r);
        ins.rf_st_data = r;
        take_bits(32, r);
        ins.pc = {r[31:2], 2'b00};
        id_ex_i = ins;
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        stall_i     = 1'b0;
        flush_i     = 1'b0;
        id_ex_i     = '0;
        lfsr_state  = LFSR_SEED;
        cycle_count = 0;
        model_q     = '0;
        model_known = 1'b0;

        // Traffic during reset must never reach the control bits
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk_i);
            check_cycle();
            drive_random();
        end
        stall_i = 1'b0;
        flush_i = 1'b0;
        id_ex_i = '0;
        rst_n_i = 1'b1;

        // Quiet inputs right after reset keep every control output low
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(negedge clk_i);
            check_cycle();
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk_i);
            check_cycle();
            drive_random();
        end

        // Result of the last instruction
        @(negedge clk_i);
        check_cycle();

        $display("All tests passed");
        $finish;
    end

endmodule : ex_stage_tb

`default_nettype wire

// File: project.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_stage.sv
test/ex_stage_tb.sv

// File: Makefile
# Verilator simulation of the execute stage

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
